/* flist.f */
+incdir+testbench
source/usb_aon_pkg.sv
source/usb_aon_filter.sv
source/usb_aon_line_decode.sv
source/usb_aon_wake_ctrl.sv
source/usb_aon_event_latch.sv
source/usb_aon_wake_top.sv
testbench/tb_usb_aon_wake.sv

/* Bender.yml */
package:
  name: usb_aon_wake

sources:
  # RTL in compile order
  - source/usb_aon_pkg.sv
  - source/usb_aon_filter.sv
  - source/usb_aon_line_decode.sv
  - source/usb_aon_wake_ctrl.sv
  - source/usb_aon_event_latch.sv
  - source/usb_aon_wake_top.sv

  # Testbench
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_usb_aon_wake.sv

/* testbench/tb_usb_aon_wake_table.svh */
`ifndef TB_USB_AON_WAKE_TABLE_SVH
`define TB_USB_AON_WAKE_TABLE_SVH

// One row of stimulus and the outputs expected once the row has settled
typedef struct packed {
  // Bus pins as {D+, D-}
  logic [1:0] pins;
  logic       sense;
  // Pull-up enables from the IP as {D+, D-}
  logic [1:0] ip_pu;
  // One cycle strobes as {suspend request, wake acknowledge}
  logic [1:0] strobe;
  // Cycles to wait before the outputs are compared
  logic [7:0] hold;
  // Nonzero means the pins return to their previous values after this many cycles
  logic [3:0] glitch;
  // Pull-up outputs as {D+, D-}
  logic [1:0] exp_pu;
  // Expected {active, wake request, not idle, bus reset, sense lost}
  logic [4:0] exp_flags;
} row_t;

localparam int unsigned NumRows = 24;

function automatic row_t table_row(input int unsigned idx);
  row_t row;
  row = '0;
  case (idx)
    // Idle with both IP pull-ups off, so every output is low
    0:  row = {2'b10, 1'b1, 2'b00, 2'b00, 8'd10, 4'd0, 2'b00, 5'b00000};
    // Idle, pull-ups follow the IP for the D+ and D- patterns
    1:  row = {2'b10, 1'b1, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b00000};
    2:  row = {2'b01, 1'b1, 2'b01, 2'b00, 8'd12, 4'd0, 2'b01, 5'b00000};
    // Line activity in idle is ordinary traffic and latches nothing
    3:  row = {2'b01, 1'b1, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b00000};
    4:  row = {2'b00, 1'b0, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b00000};
    5:  row = {2'b10, 1'b1, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b00000};
    // Suspend entry, then the IP drops its pull-ups while they stay held
    6:  row = {2'b10, 1'b1, 2'b10, 2'b10, 8'd12, 4'd0, 2'b10, 5'b10000};
    7:  row = {2'b10, 1'b1, 2'b00, 2'b00, 8'd12, 4'd0, 2'b10, 5'b10000};
    // Resume K from the host
    8:  row = {2'b01, 1'b1, 2'b00, 2'b00, 8'd12, 4'd0, 2'b10, 5'b11100};
    9:  row = {2'b10, 1'b1, 2'b00, 2'b01, 8'd12, 4'd0, 2'b00, 5'b00000};
    10: row = {2'b10, 1'b1, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b00000};
    // Bus reset, where SE0 also counts as leaving J
    11: row = {2'b10, 1'b1, 2'b10, 2'b10, 8'd12, 4'd0, 2'b10, 5'b10000};
    12: row = {2'b00, 1'b1, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b11110};
    13: row = {2'b10, 1'b1, 2'b10, 2'b01, 8'd12, 4'd0, 2'b10, 5'b00000};
    // VBUS goes away
    14: row = {2'b10, 1'b1, 2'b10, 2'b10, 8'd12, 4'd0, 2'b10, 5'b10000};
    15: row = {2'b10, 1'b0, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b11001};
    16: row = {2'b10, 1'b1, 2'b10, 2'b01, 8'd12, 4'd0, 2'b10, 5'b00000};
    // Two cycle glitches on each condition stay below every filter length
    17: row = {2'b10, 1'b1, 2'b10, 2'b10, 8'd12, 4'd0, 2'b10, 5'b10000};
    18: row = {2'b01, 1'b1, 2'b10, 2'b00, 8'd12, 4'd2, 2'b10, 5'b10000};
    19: row = {2'b00, 1'b1, 2'b10, 2'b00, 8'd12, 4'd2, 2'b10, 5'b10000};
    20: row = {2'b10, 1'b0, 2'b10, 2'b00, 8'd12, 4'd2, 2'b10, 5'b10000};
    // A real K still gets through after the glitches
    21: row = {2'b01, 1'b1, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b11100};
    // Acknowledge hands the pull-ups back to the IP
    22: row = {2'b01, 1'b1, 2'b01, 2'b01, 8'd12, 4'd0, 2'b01, 5'b00000};
    23: row = {2'b10, 1'b1, 2'b10, 2'b00, 8'd12, 4'd0, 2'b10, 5'b00000};
    default: row = '0;
  endcase
  return row;
endfunction

`endif

/* testbench/tb_usb_aon_wake.sv */
`timescale 1ns/10ps

module tb_usb_aon_wake;

  `include "tb_usb_aon_wake_table.svh"

  localparam int unsigned NotIdleCycles = 4;
  localparam int unsigned ResetCycles   = 3;
  localparam int unsigned SenseCycles   = 3;
  localparam int unsigned RstCycles     = 10;

  logic clk_aon_i;
  logic rst_aon_ni;
  logic usb_dp_i, usb_dn_i, usb_sense_i;
  logic usbdev_dppullup_en_i, usbdev_dnpullup_en_i;
  logic suspend_req_aon_i, wake_ack_aon_i;
  logic usb_dppullup_en_o, usb_dnpullup_en_o;
  logic wake_req_aon_o, bus_not_idle_aon_o, bus_reset_aon_o, sense_lost_aon_o;
  logic wake_detect_active_aon_o;

  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned cycle_count = 0;

  usb_aon_wake_top #(
    .NotIdleCycles (NotIdleCycles),
    .ResetCycles   (ResetCycles),
    .SenseCycles   (SenseCycles)
  ) UUT (
    .clk_aon_i                (clk_aon_i),
    .rst_aon_ni               (rst_aon_ni),
    .usb_dp_i                 (usb_dp_i),
    .usb_dn_i                 (usb_dn_i),
    .usb_sense_i              (usb_sense_i),
    .usbdev_dppullup_en_i     (usbdev_dppullup_en_i),
    .usbdev_dnpullup_en_i     (usbdev_dnpullup_en_i),
    .suspend_req_aon_i        (suspend_req_aon_i),
    .wake_ack_aon_i           (wake_ack_aon_i),
    .usb_dppullup_en_o        (usb_dppullup_en_o),
    .usb_dnpullup_en_o        (usb_dnpullup_en_o),
    .wake_req_aon_o           (wake_req_aon_o),
    .bus_not_idle_aon_o       (bus_not_idle_aon_o),
    .bus_reset_aon_o          (bus_reset_aon_o),
    .sense_lost_aon_o         (sense_lost_aon_o),
    .wake_detect_active_aon_o (wake_detect_active_aon_o)
  );

  initial begin
    clk_aon_i = 1'b0;
    forever #2 clk_aon_i = ~clk_aon_i;
  end

  // Reset, every row with its hold, and some slack per row for driving and sampling
  function automatic int unsigned cycle_budget();
    int unsigned sum;
    row_t r;
    sum = RstCycles;
    for (int unsigned i = 0; i < NumRows; i++) begin
      r = table_row(i);
      sum += r.hold + 10;
    end
    return sum;
  endfunction

  task automatic compare_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  always @(posedge clk_aon_i) begin
    cycle_count++;
    if (cycle_count > cycle_budget()) begin
      $display("Run timed out after %0d cycles before the table was done", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin : run_table
    row_t r;
    int unsigned idx;
    int unsigned c;
    int unsigned errs_before;
    logic [1:0] prev_pins;
    logic prev_sense;
    // J for a full speed device with the sense line present
    prev_pins = 2'b10;
    prev_sense = 1'b1;
    rst_aon_ni = 1'b0;
    {usb_dp_i, usb_dn_i} = prev_pins;
    usb_sense_i = prev_sense;
    usbdev_dppullup_en_i = 1'b0;
    usbdev_dnpullup_en_i = 1'b0;
    suspend_req_aon_i = 1'b0;
    wake_ack_aon_i = 1'b0;
    repeat (RstCycles) @(posedge clk_aon_i);
    #1 rst_aon_ni = 1'b1;
    for (idx = 0; idx < NumRows; idx++) begin
      r = table_row(idx);
      @(posedge clk_aon_i);
      #1;
      {usb_dp_i, usb_dn_i} = r.pins;
      usb_sense_i = r.sense;
      {usbdev_dppullup_en_i, usbdev_dnpullup_en_i} = r.ip_pu;
      {suspend_req_aon_i, wake_ack_aon_i} = r.strobe;
      for (c = 0; c < r.hold; c++) begin
        @(posedge clk_aon_i);
        #1;
        // Strobes are single cycle pulses
        if (c == 0) begin
          suspend_req_aon_i = 1'b0;
          wake_ack_aon_i = 1'b0;
        end
        if ((r.glitch != 0) && (c + 1 == r.glitch)) begin
          {usb_dp_i, usb_dn_i} = prev_pins;
          usb_sense_i = prev_sense;
        end
      end
      // Outputs are compared away from the edge where they change
      @(negedge clk_aon_i);
      errs_before = error_count;
      compare_bit("usb_dppullup_en_o", usb_dppullup_en_o, r.exp_pu[1]);
      compare_bit("usb_dnpullup_en_o", usb_dnpullup_en_o, r.exp_pu[0]);
      compare_bit("wake_detect_active_aon_o", wake_detect_active_aon_o, r.exp_flags[4]);
      compare_bit("wake_req_aon_o", wake_req_aon_o, r.exp_flags[3]);
      compare_bit("bus_not_idle_aon_o", bus_not_idle_aon_o, r.exp_flags[2]);
      compare_bit("bus_reset_aon_o", bus_reset_aon_o, r.exp_flags[1]);
      compare_bit("sense_lost_aon_o", sense_lost_aon_o, r.exp_flags[0]);
      $display("row %0d %s", idx, (error_count == errs_before) ? "ok" : "failed");
      // After a glitch the line is back where it was, so the old values stay current
      if (r.glitch == 0) begin
        prev_pins = r.pins;
        prev_sense = r.sense;
      end
    end
    $display("%0d rows, %0d checks, %0d errors", NumRows, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* source/usb_aon_wake_top.sv */
`timescale 1ns/10ps

module usb_aon_wake_top #(
  parameter int unsigned NotIdleCycles = 4,
  parameter int unsigned ResetCycles   = 3,
  parameter int unsigned SenseCycles   = 3
) (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  // Bus pins and VBUS sense
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_sense_i,
  // Pull-up enables from the device IP
  input  logic usbdev_dppullup_en_i,
  input  logic usbdev_dnpullup_en_i,
  // Strobes from the IP, already in the always-on domain
  input  logic suspend_req_aon_i,
  input  logic wake_ack_aon_i,
  // Pull-up enables that reach the pads
  output logic usb_dppullup_en_o,
  output logic usb_dnpullup_en_o,
  output logic wake_req_aon_o,
  // Events seen while monitoring
  output logic bus_not_idle_aon_o,
  output logic bus_reset_aon_o,
  output logic sense_lost_aon_o,
  output logic wake_detect_active_aon_o
);

  // Pull-up values on the pads, also the reference for the idle compare
  usb_aon_pkg::pullup_en_t pullup_en;

  // Filtered bus events from decode
  usb_aon_pkg::event_vec_t events;

  // High while the detector owns the pull-ups
  logic wake_active;

  usb_aon_line_decode #(
    .NotIdleCycles (NotIdleCycles),
    .ResetCycles   (ResetCycles),
    .SenseCycles   (SenseCycles)
  ) u_line_decode (
    .clk_aon_i   (clk_aon_i),
    .rst_aon_ni  (rst_aon_ni),
    .usb_dp_i    (usb_dp_i),
    .usb_dn_i    (usb_dn_i),
    .usb_sense_i (usb_sense_i),
    .pullup_en_i (pullup_en),
    .events_o    (events)
  );

  usb_aon_wake_ctrl u_wake_ctrl (
    .clk_aon_i            (clk_aon_i),
    .rst_aon_ni           (rst_aon_ni),
    .usbdev_dppullup_en_i (usbdev_dppullup_en_i),
    .usbdev_dnpullup_en_i (usbdev_dnpullup_en_i),
    .suspend_req_aon_i    (suspend_req_aon_i),
    .wake_ack_aon_i       (wake_ack_aon_i),
    .pullup_en_o          (pullup_en),
    .wake_active_o        (wake_active)
  );

  usb_aon_event_latch u_event_latch (
    .clk_aon_i          (clk_aon_i),
    .rst_aon_ni         (rst_aon_ni),
    .events_i           (events),
    .wake_active_i      (wake_active),
    .bus_not_idle_aon_o (bus_not_idle_aon_o),
    .bus_reset_aon_o    (bus_reset_aon_o),
    .sense_lost_aon_o   (sense_lost_aon_o),
    .wake_req_aon_o     (wake_req_aon_o)
  );

  // Upper bit is D+ and lower bit is D-
  assign usb_dppullup_en_o        = pullup_en[1];
  assign usb_dnpullup_en_o        = pullup_en[0];
  assign wake_detect_active_aon_o = wake_active;

endmodule

/* source/usb_aon_event_latch.sv */
`timescale 1ns/10ps

module usb_aon_event_latch (
  input  logic                    clk_aon_i,
  input  logic                    rst_aon_ni,
  input  usb_aon_pkg::event_vec_t events_i,
  input  logic                    wake_active_i,
  output logic                    bus_not_idle_aon_o,
  output logic                    bus_reset_aon_o,
  output logic                    sense_lost_aon_o,
  output logic                    wake_req_aon_o
);

  // Sticky copy of each filtered event, one flag per bit
  usb_aon_pkg::event_vec_t flags_d, flags_q;

  // Sticky wake request towards the power manager
  logic wake_req_d, wake_req_q;

  logic any_event;

  assign any_event = |events_i;

  // A flag collects its event while monitoring and drops once monitoring ends
  // Events seen in idle belong to normal bus traffic and are ignored
  assign flags_d = (flags_q | events_i) & {3{wake_active_i}};

  // Any event asks for a wake, and the request stays up until the acknowledge
  assign wake_req_d = wake_active_i & (any_event | wake_req_q);

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      flags_q    <= '0;
      wake_req_q <= 1'b0;
    end else begin
      flags_q    <= flags_d;
      wake_req_q <= wake_req_d;
    end
  end

  assign bus_not_idle_aon_o = flags_q[usb_aon_pkg::EvNotIdle];
  assign bus_reset_aon_o    = flags_q[usb_aon_pkg::EvBusReset];
  assign sense_lost_aon_o   = flags_q[usb_aon_pkg::EvSenseLost];
  assign wake_req_aon_o     = wake_req_q;

  // A request can only come out of a cycle in which the detector was active
  wake_req_active_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    wake_req_aon_o |-> $past(wake_active_i));

endmodule

/* source/usb_aon_wake_ctrl.sv */
`timescale 1ns/10ps

module usb_aon_wake_ctrl (
  input  logic                    clk_aon_i,
  input  logic                    rst_aon_ni,
  input  logic                    usbdev_dppullup_en_i,
  input  logic                    usbdev_dnpullup_en_i,
  input  logic                    suspend_req_aon_i,
  input  logic                    wake_ack_aon_i,
  output usb_aon_pkg::pullup_en_t pullup_en_o,
  output logic                    wake_active_o
);

  usb_aon_pkg::wake_state_e state_d, state_q;

  // Pull-up enables as driven by the IP, in its own clock domain
  usb_aon_pkg::pullup_en_t pullup_ip;

  // Two flop synchronizer for the IP pull-up enables
  usb_aon_pkg::pullup_en_t pullup_sync_q1, pullup_sync_q2;

  // Pull-up values kept while the detector owns the pins
  usb_aon_pkg::pullup_en_t hold_d, hold_q;

  logic active;

  assign pullup_ip = {usbdev_dppullup_en_i, usbdev_dnpullup_en_i};

  // Suspend entry hands the pins to this block, the acknowledge hands them back
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      usb_aon_pkg::WakeIdle: begin
        if (suspend_req_aon_i) begin
          state_d = usb_aon_pkg::WakeActive;
        end
      end
      usb_aon_pkg::WakeActive: begin
        if (wake_ack_aon_i) begin
          state_d = usb_aon_pkg::WakeIdle;
        end
      end
      default: state_d = usb_aon_pkg::WakeIdle;
    endcase
  end

  assign active = (state_q == usb_aon_pkg::WakeActive);

  // While idle the hold register keeps tracking the IP
  // The value it has on the entry edge is the one that stays frozen
  assign hold_d = active ? hold_q : pullup_sync_q2;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      state_q        <= usb_aon_pkg::WakeIdle;
      pullup_sync_q1 <= '0;
      pullup_sync_q2 <= '0;
      hold_q         <= '0;
    end else begin
      state_q        <= state_d;
      pullup_sync_q1 <= pullup_ip;
      pullup_sync_q2 <= pullup_sync_q1;
      hold_q         <= hold_d;
    end
  end

  // In idle the IP drives the pins directly, with no added delay
  assign pullup_en_o   = active ? hold_q : pullup_ip;
  assign wake_active_o = active;

  state_known_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    !$isunknown(state_q));

  // Once in control the pins must not move until control is handed back
  pullup_held_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    (state_q == usb_aon_pkg::WakeActive) ##1 (state_q == usb_aon_pkg::WakeActive)
    |-> $stable(pullup_en_o));

endmodule

/* source/usb_aon_line_decode.sv */
`timescale 1ns/10ps

module usb_aon_line_decode #(
  parameter int unsigned NotIdleCycles = 4,
  parameter int unsigned ResetCycles   = 3,
  parameter int unsigned SenseCycles   = 3
) (
  input  logic                    clk_aon_i,
  input  logic                    rst_aon_ni,
  input  logic                    usb_dp_i,
  input  logic                    usb_dn_i,
  input  logic                    usb_sense_i,
  input  usb_aon_pkg::pullup_en_t pullup_en_i,
  output usb_aon_pkg::event_vec_t events_o
);

  // Raw line state straight from the pins, still asynchronous
  usb_aon_pkg::line_state_t line_state;

  // Unfiltered conditions
  logic not_idle_raw;
  logic se0_raw;
  logic sense_lost_raw;

  // Conditions after synchronizer and stability filter
  logic not_idle_filt;
  logic se0_filt;
  logic sense_lost_filt;

  assign line_state = {usb_dp_i, usb_dn_i};

  // During suspend only the device pull-up shapes the idle line
  // So any line state other than the pull-up pattern was caused by the host
  // Comparing against the pull-ups also makes this independent of pin flipping
  assign not_idle_raw = (line_state != pullup_en_i);

  // Both lines low is SE0, the host driving a bus reset
  assign se0_raw = (line_state == 2'b00);

  // Sense low means VBUS has gone away
  assign sense_lost_raw = ~usb_sense_i;

  // The non-idle filter is the longest, giving the main IP a chance to see resume first
  usb_aon_filter #(
    .Cycles (NotIdleCycles)
  ) u_filter_not_idle (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (not_idle_raw),
    .filter_o   (not_idle_filt)
  );

  usb_aon_filter #(
    .Cycles (ResetCycles)
  ) u_filter_bus_reset (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (se0_raw),
    .filter_o   (se0_filt)
  );

  usb_aon_filter #(
    .Cycles (SenseCycles)
  ) u_filter_sense (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (sense_lost_raw),
    .filter_o   (sense_lost_filt)
  );

  // Pack the filtered levels at their fixed bit positions
  always_comb begin
    events_o                           = '0;
    events_o[usb_aon_pkg::EvNotIdle]   = not_idle_filt;
    events_o[usb_aon_pkg::EvBusReset]  = se0_filt;
    events_o[usb_aon_pkg::EvSenseLost] = sense_lost_filt;
  end

endmodule

/* source/usb_aon_filter.sv */
`timescale 1ns/10ps

module usb_aon_filter #(
  parameter int unsigned Cycles = 4
) (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic filter_i,
  output logic filter_o
);

  // The counter has to be able to hold the value Cycles itself
  localparam int unsigned CntW = $clog2(Cycles + 1);

  typedef logic [CntW-1:0] cnt_t;

  // Two flop synchronizer stages for the asynchronous pin level
  logic sync_q1, sync_q2;

  // Candidate value, which is the synchronized level one edge later
  logic stored_q;

  // Number of consecutive edges on which the candidate was unchanged
  cnt_t count_q;

  // Filtered output register
  logic filter_q;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      sync_q1  <= 1'b0;
      sync_q2  <= 1'b0;
      stored_q <= 1'b0;
      count_q  <= '0;
      filter_q <= 1'b0;
    end else begin
      sync_q1  <= filter_i;
      sync_q2  <= sync_q1;
      stored_q <= sync_q2;
      // A new synchronized value restarts the count of equal samples
      if (sync_q2 != stored_q) begin
        count_q <= '0;
      end else if (count_q != cnt_t'(Cycles)) begin
        count_q <= count_q + cnt_t'(1);
      end
      // Only a value that stayed put long enough makes it to the output
      if (count_q == cnt_t'(Cycles)) begin
        filter_q <= stored_q;
      end
    end
  end

  assign filter_o = filter_q;

  // Any output change must be preceded by a full run of equal samples
  filter_settled_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    $changed(filter_o) |-> ($past(count_q) == cnt_t'(Cycles)));

endmodule

/* source/usb_aon_pkg.sv */
package usb_aon_pkg;

  // Pair of bus lines as seen on the pins
  // D+ sits in the upper bit and D- in the lower bit
  typedef logic [1:0] line_state_t;

  // Pull-up enables for D+ and D-
  // The bit order matches line_state_t so the two compare directly
  typedef logic [1:0] pullup_en_t;

  // One filtered bus event per bit
  typedef logic [2:0] event_vec_t;

  // Bit positions inside event_vec_t

  // The line state differs from the pattern set by the pull-ups
  // This covers a resume K as well as any other departure from J
  localparam int unsigned EvNotIdle = 0;

  // Both lines are low, which the host uses to signal a bus reset
  localparam int unsigned EvBusReset = 1;

  // VBUS sense has dropped, meaning the cable was pulled
  localparam int unsigned EvSenseLost = 2;

  // Wake control FSM states
  typedef enum logic {
    // The device IP drives the pull-ups and the detector only watches
    WakeIdle   = 1'b0,
    // The detector holds the pull-ups and monitors the bus for events
    WakeActive = 1'b1
  } wake_state_e;

  // The FSM is a single flop, so the active level is simply the state bit
  // Other modules only ever see that level, never the enum itself

endpackage
